// File: rtl/pcie_config_params.svh
`ifndef PCIE_CONFIG_PARAMS_SVH
`define PCIE_CONFIG_PARAMS_SVH

// Bus widths
`define AXIL_DATA_W 32
`define AXIL_ADDR_W 16

// Descriptor widths
`define PCIE_ADDR_W 64
`define RAM_ADDR_W  32
`define DMA_LEN_W   16
`define DMA_TAG_W   32

// Identification words
`define FW_ID          32'h0000_0000
`define FW_VER         32'h0000_0001
`define BOARD_ID       32'h1CE4_0003
`define BOARD_VER      32'h0000_0001
`define FPGA_ID        32'h0382_3093
`define IF_COUNT       32'h0000_0002
`define IF_STRIDE      32'h0000_8000
`define IF_CTRL_OFFSET 32'h0000_0400

// Identification addresses
`define REG_FW_ID          16'h0000
`define REG_FW_VER         16'h0004
`define REG_BOARD_ID       16'h0008
`define REG_BOARD_VER      16'h000C
`define REG_IF_COUNT       16'h0020
`define REG_IF_STRIDE      16'h0024
`define REG_IF_CTRL_OFFSET 16'h002C
`define REG_FPGA_ID        16'h0040

// GPIO and DMA channel offsets
`define REG_GPIO_OUT    16'h0100
`define REG_GPIO_IN     16'h0104
`define REG_DMA_RD_BASE 16'h0440
`define REG_DMA_WR_BASE 16'h0460

// Offsets inside one channel
`define DESC_OFS_ADDR_LO 16'h0000
`define DESC_OFS_ADDR_HI 16'h0004
`define DESC_OFS_RAM     16'h0008
`define DESC_OFS_LEN     16'h0010
`define DESC_OFS_TAG     16'h0014
`define DESC_OFS_STATUS  16'h0018

`endif

// File: rtl/cfg_regs_pkg.sv
`include "pcie_config_params.svh"

package cfg_regs_pkg;

  typedef logic [`AXIL_ADDR_W-1:0]   reg_addr_t;
  typedef logic [`AXIL_DATA_W-1:0]   reg_data_t;
  typedef logic [`AXIL_DATA_W/8-1:0] reg_strb_t;

  // What software writes to REG_GPIO_OUT
  typedef struct packed {
    logic [13:0] rsvd_hi;
    logic        i2c_sda;
    logic        i2c_scl;
    logic [3:0]  rsvd_15_12;
    logic        qsfp1_modsell;
    logic        rsvd_10;
    logic        qsfp0_modsell;
    logic        rsvd_8;
    logic        rsvd_7;
    logic        qsfp1_lpmode;
    logic        rsvd_5;
    logic        qsfp1_resetl;
    logic        rsvd_3;
    logic        qsfp0_lpmode;
    logic        rsvd_1;
    logic        qsfp0_resetl;
  } gpio_out_t;

  // Pin state as seen in REG_GPIO_IN
  typedef struct packed {
    logic [13:0] rsvd_hi;
    logic        i2c_sda;
    logic        i2c_scl;
    logic [3:0]  rsvd_15_12;
    logic        qsfp1_modsell;
    logic        qsfp1_modprsl;
    logic        qsfp0_modsell;
    logic        qsfp0_modprsl;
    logic        rsvd_7;
    logic        qsfp1_lpmode;
    logic        qsfp1_intl;
    logic        qsfp1_resetl;
    logic        rsvd_3;
    logic        qsfp0_lpmode;
    logic        qsfp0_intl;
    logic        qsfp0_resetl;
  } gpio_in_t;

  typedef union packed {
    gpio_out_t out_view;
    gpio_in_t  in_view;
  } gpio_word_u;

  // Writable GPIO bits and their power-up state
  localparam reg_data_t GPIO_OUT_MASK = 32'h0003_0A55;
  localparam reg_data_t GPIO_OUT_RST  = 32'h0003_0A11;

endpackage

// File: rtl/dma_desc_pkg.sv
`include "pcie_config_params.svh"

package dma_desc_pkg;

  // Host side address
  typedef logic [`PCIE_ADDR_W-1:0] pcie_addr_t;

  // On-card RAM address
  typedef logic [`RAM_ADDR_W-1:0]  ram_addr_t;

  typedef logic [`DMA_LEN_W-1:0]   dma_len_t;

  // Tags are one-hot by convention so completions can be OR-ed
  typedef logic [`DMA_TAG_W-1:0]   dma_tag_t;

endpackage

// File: rtl/axil_reg_port.sv
`include "pcie_config_params.svh"

module axil_reg_port (
  input  logic                    pcie_clk,
  input  logic                    pcie_rst,
  input  cfg_regs_pkg::reg_addr_t awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  cfg_regs_pkg::reg_data_t wdata_i,
  input  cfg_regs_pkg::reg_strb_t wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output logic [1:0]              bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  cfg_regs_pkg::reg_addr_t araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output cfg_regs_pkg::reg_data_t rdata_o,
  output logic [1:0]              rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output logic                    wr_en_o,
  output cfg_regs_pkg::reg_addr_t wr_addr_o,
  output cfg_regs_pkg::reg_data_t wr_data_o,
  output cfg_regs_pkg::reg_strb_t wr_strb_o,
  output logic                    rd_en_o,
  output cfg_regs_pkg::reg_addr_t rd_addr_o,
  input  cfg_regs_pkg::reg_data_t gpio_rd_data_i,
  input  cfg_regs_pkg::reg_data_t dma_rd_rd_data_i,
  input  cfg_regs_pkg::reg_data_t dma_wr_rd_data_i
);
  import cfg_regs_pkg::*;

  reg_data_t id_rd_data;

  assign bresp_o = 2'b00;
  assign rresp_o = 2'b00;

  // Accept only when the previous response has been taken
  assign wr_en_o   = awvalid_i && wvalid_i && !bvalid_o;
  assign wr_addr_o = {awaddr_i[`AXIL_ADDR_W-1:2], 2'b00};
  assign wr_data_o = wdata_i;
  assign wr_strb_o = wstrb_i;
  assign rd_en_o   = arvalid_i && !rvalid_o;
  assign rd_addr_o = {araddr_i[`AXIL_ADDR_W-1:2], 2'b00};

  always_comb begin
    case (rd_addr_o)
      `REG_FW_ID:          id_rd_data = `FW_ID;
      `REG_FW_VER:         id_rd_data = `FW_VER;
      `REG_BOARD_ID:       id_rd_data = `BOARD_ID;
      `REG_BOARD_VER:      id_rd_data = `BOARD_VER;
      `REG_IF_COUNT:       id_rd_data = `IF_COUNT;
      `REG_IF_STRIDE:      id_rd_data = `IF_STRIDE;
      `REG_IF_CTRL_OFFSET: id_rd_data = `IF_CTRL_OFFSET;
      `REG_FPGA_ID:        id_rd_data = `FPGA_ID;
      default:             id_rd_data = '0;
    endcase
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      awready_o <= wr_en_o;
      wready_o  <= wr_en_o;
      bvalid_o  <= wr_en_o || (bvalid_o && !bready_i);
      arready_o <= rd_en_o;
      rvalid_o  <= rd_en_o || (rvalid_o && !rready_i);
    end
  end

  // Blocks return zero outside their own range
  always_ff @(posedge pcie_clk) begin
    if (rd_en_o) begin
      rdata_o <= id_rd_data | gpio_rd_data_i | dma_rd_rd_data_i | dma_wr_rd_data_i;
    end
  end

  bvalid_hold_a: assert property (
    @(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o && !bready_i |=> bvalid_o
  );

endmodule

// File: rtl/gpio_regs.sv
`include "pcie_config_params.svh"

module gpio_regs (
  input  logic                    pcie_clk,
  input  logic                    pcie_rst,
  input  logic                    wr_en_i,
  input  cfg_regs_pkg::reg_addr_t wr_addr_i,
  input  cfg_regs_pkg::reg_data_t wr_data_i,
  input  cfg_regs_pkg::reg_strb_t wr_strb_i,
  input  cfg_regs_pkg::reg_addr_t rd_addr_i,
  output cfg_regs_pkg::reg_data_t rd_data_o,
  output logic                    qsfp0_modsell_o,
  output logic                    qsfp0_resetl_o,
  output logic                    qsfp0_lpmode_o,
  input  logic                    qsfp0_modprsl_i,
  input  logic                    qsfp0_intl_i,
  output logic                    qsfp1_modsell_o,
  output logic                    qsfp1_resetl_o,
  output logic                    qsfp1_lpmode_o,
  input  logic                    qsfp1_modprsl_i,
  input  logic                    qsfp1_intl_i,
  input  logic                    i2c_scl_i,
  output logic                    i2c_scl_o,
  output logic                    i2c_scl_t_o,
  input  logic                    i2c_sda_i,
  output logic                    i2c_sda_o,
  output logic                    i2c_sda_t_o
);
  import cfg_regs_pkg::*;

  // Input vector order is {intl1, modprsl1, intl0, modprsl0, sda, scl}
  localparam logic [5:0] IN_RST = 6'b00_00_11;

  gpio_word_u out_reg;
  gpio_word_u out_s1;
  gpio_word_u out_s2;
  gpio_word_u in_word;
  logic [5:0] in_s1;
  logic [5:0] in_s2;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      out_reg <= GPIO_OUT_RST;
    end else if (wr_en_i && wr_addr_i == `REG_GPIO_OUT) begin
      for (int b = 0; b < $bits(reg_strb_t); b++) begin
        if (wr_strb_i[b]) begin
          out_reg[8*b +: 8] <= wr_data_i[8*b +: 8] & GPIO_OUT_MASK[8*b +: 8];
        end
      end
    end
  end

  // Two register stages towards the pins
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      out_s1 <= GPIO_OUT_RST;
      out_s2 <= GPIO_OUT_RST;
    end else begin
      out_s1 <= out_reg;
      out_s2 <= out_s1;
    end
  end

  assign qsfp0_modsell_o = out_s2.out_view.qsfp0_modsell;
  assign qsfp0_resetl_o  = out_s2.out_view.qsfp0_resetl;
  assign qsfp0_lpmode_o  = out_s2.out_view.qsfp0_lpmode;
  assign qsfp1_modsell_o = out_s2.out_view.qsfp1_modsell;
  assign qsfp1_resetl_o  = out_s2.out_view.qsfp1_resetl;
  assign qsfp1_lpmode_o  = out_s2.out_view.qsfp1_lpmode;
  assign i2c_scl_o       = out_s2.out_view.i2c_scl;
  assign i2c_sda_o       = out_s2.out_view.i2c_sda;
  // Open drain, so the pad is released whenever the line is high
  assign i2c_scl_t_o     = out_s2.out_view.i2c_scl;
  assign i2c_sda_t_o     = out_s2.out_view.i2c_sda;

  // Input synchronizer
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      in_s1 <= IN_RST;
      in_s2 <= IN_RST;
    end else begin
      in_s1 <= {qsfp1_intl_i, qsfp1_modprsl_i, qsfp0_intl_i, qsfp0_modprsl_i,
                i2c_sda_i, i2c_scl_i};
      in_s2 <= in_s1;
    end
  end

  always_comb begin
    in_word = '0;
    in_word.in_view.qsfp0_resetl  = out_s2.out_view.qsfp0_resetl;
    in_word.in_view.qsfp0_lpmode  = out_s2.out_view.qsfp0_lpmode;
    in_word.in_view.qsfp0_modsell = out_s2.out_view.qsfp0_modsell;
    in_word.in_view.qsfp1_resetl  = out_s2.out_view.qsfp1_resetl;
    in_word.in_view.qsfp1_lpmode  = out_s2.out_view.qsfp1_lpmode;
    in_word.in_view.qsfp1_modsell = out_s2.out_view.qsfp1_modsell;
    in_word.in_view.i2c_scl       = in_s2[0];
    in_word.in_view.i2c_sda       = in_s2[1];
    in_word.in_view.qsfp0_modprsl = in_s2[2];
    in_word.in_view.qsfp0_intl    = in_s2[3];
    in_word.in_view.qsfp1_modprsl = in_s2[4];
    in_word.in_view.qsfp1_intl    = in_s2[5];
  end

  always_comb begin
    case (rd_addr_i)
      `REG_GPIO_OUT: rd_data_o = out_reg;
      `REG_GPIO_IN:  rd_data_o = in_word;
      default:       rd_data_o = '0;
    endcase
  end

endmodule

// File: rtl/dma_desc_channel.sv
`include "pcie_config_params.svh"

module dma_desc_channel #(
  parameter cfg_regs_pkg::reg_addr_t BASE_ADDR = `REG_DMA_RD_BASE
) (
  input  logic                    pcie_clk,
  input  logic                    pcie_rst,
  input  logic                    wr_en_i,
  input  cfg_regs_pkg::reg_addr_t wr_addr_i,
  input  cfg_regs_pkg::reg_data_t wr_data_i,
  input  logic                    rd_en_i,
  input  cfg_regs_pkg::reg_addr_t rd_addr_i,
  output cfg_regs_pkg::reg_data_t rd_data_o,
  output dma_desc_pkg::pcie_addr_t desc_pcie_addr_o,
  output dma_desc_pkg::ram_addr_t  desc_ram_addr_o,
  output dma_desc_pkg::dma_len_t   desc_len_o,
  output dma_desc_pkg::dma_tag_t   desc_tag_o,
  output logic                    desc_valid_o,
  input  logic                    desc_ready_i,
  input  dma_desc_pkg::dma_tag_t   status_tag_i,
  input  logic                    status_valid_i
);
  import cfg_regs_pkg::*;
  import dma_desc_pkg::*;

  localparam reg_addr_t ADDR_LO_A = BASE_ADDR + `DESC_OFS_ADDR_LO;
  localparam reg_addr_t ADDR_HI_A = BASE_ADDR + `DESC_OFS_ADDR_HI;
  localparam reg_addr_t RAM_A     = BASE_ADDR + `DESC_OFS_RAM;
  localparam reg_addr_t LEN_A     = BASE_ADDR + `DESC_OFS_LEN;
  localparam reg_addr_t TAG_A     = BASE_ADDR + `DESC_OFS_TAG;
  localparam reg_addr_t STATUS_A  = BASE_ADDR + `DESC_OFS_STATUS;

  logic     wr_tag;
  logic     rd_status;
  dma_tag_t status_q;

  assign wr_tag    = wr_en_i && wr_addr_i == TAG_A;
  assign rd_status = rd_en_i && rd_addr_i == STATUS_A;

  always_ff @(posedge pcie_clk) begin
    if (wr_en_i) begin
      case (wr_addr_i)
        ADDR_LO_A: desc_pcie_addr_o[31:0] <= wr_data_i;
        ADDR_HI_A: desc_pcie_addr_o[`PCIE_ADDR_W-1:32] <= wr_data_i;
        RAM_A:     desc_ram_addr_o <= ram_addr_t'(wr_data_i);
        LEN_A:     desc_len_o <= dma_len_t'(wr_data_i);
        TAG_A:     desc_tag_o <= dma_tag_t'(wr_data_i);
        default:   ;
      endcase
    end
  end

  // Tag write launches the descriptor
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
    end else begin
      desc_valid_o <= wr_tag || (desc_valid_o && !desc_ready_i);
    end
  end

  // Clear on read, a completion in that cycle starts the new word
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      status_q <= '0;
    end else if (rd_status) begin
      status_q <= status_valid_i ? status_tag_i : '0;
    end else if (status_valid_i) begin
      status_q <= status_q | status_tag_i;
    end
  end

  assign rd_data_o = (rd_addr_i == STATUS_A) ? reg_data_t'(status_q) : '0;

  desc_valid_hold_a: assert property (
    @(posedge pcie_clk) disable iff (pcie_rst)
    desc_valid_o && !desc_ready_i |=> desc_valid_o
  );

endmodule

// File: rtl/pcie_config_top.sv
`include "pcie_config_params.svh"

module pcie_config_top (
  input  logic                     pcie_clk,
  input  logic                     pcie_rst,
  input  cfg_regs_pkg::reg_addr_t  awaddr_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  cfg_regs_pkg::reg_data_t  wdata_i,
  input  cfg_regs_pkg::reg_strb_t  wstrb_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  output logic [1:0]               bresp_o,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  input  cfg_regs_pkg::reg_addr_t  araddr_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  output cfg_regs_pkg::reg_data_t  rdata_o,
  output logic [1:0]               rresp_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output dma_desc_pkg::pcie_addr_t dma_rd_desc_pcie_addr_o,
  output dma_desc_pkg::ram_addr_t  dma_rd_desc_ram_addr_o,
  output dma_desc_pkg::dma_len_t   dma_rd_desc_len_o,
  output dma_desc_pkg::dma_tag_t   dma_rd_desc_tag_o,
  output logic                     dma_rd_desc_valid_o,
  input  logic                     dma_rd_desc_ready_i,
  input  dma_desc_pkg::dma_tag_t   dma_rd_status_tag_i,
  input  logic                     dma_rd_status_valid_i,
  output dma_desc_pkg::pcie_addr_t dma_wr_desc_pcie_addr_o,
  output dma_desc_pkg::ram_addr_t  dma_wr_desc_ram_addr_o,
  output dma_desc_pkg::dma_len_t   dma_wr_desc_len_o,
  output dma_desc_pkg::dma_tag_t   dma_wr_desc_tag_o,
  output logic                     dma_wr_desc_valid_o,
  input  logic                     dma_wr_desc_ready_i,
  input  dma_desc_pkg::dma_tag_t   dma_wr_status_tag_i,
  input  logic                     dma_wr_status_valid_i,
  output logic                     qsfp0_modsell_o,
  output logic                     qsfp0_resetl_o,
  output logic                     qsfp0_lpmode_o,
  input  logic                     qsfp0_modprsl_i,
  input  logic                     qsfp0_intl_i,
  output logic                     qsfp1_modsell_o,
  output logic                     qsfp1_resetl_o,
  output logic                     qsfp1_lpmode_o,
  input  logic                     qsfp1_modprsl_i,
  input  logic                     qsfp1_intl_i,
  input  logic                     i2c_scl_i,
  output logic                     i2c_scl_o,
  output logic                     i2c_scl_t_o,
  input  logic                     i2c_sda_i,
  output logic                     i2c_sda_o,
  output logic                     i2c_sda_t_o
);
  import cfg_regs_pkg::*;

  logic      wr_en;
  reg_addr_t wr_addr;
  reg_data_t wr_data;
  reg_strb_t wr_strb;
  logic      rd_en;
  reg_addr_t rd_addr;
  reg_data_t gpio_rd_data;
  reg_data_t dma_rd_rd_data;
  reg_data_t dma_wr_rd_data;

  // Bus side ports match by name
  axil_reg_port u_axil_reg_port (
    .*,
    .wr_en_o          (wr_en),
    .wr_addr_o        (wr_addr),
    .wr_data_o        (wr_data),
    .wr_strb_o        (wr_strb),
    .rd_en_o          (rd_en),
    .rd_addr_o        (rd_addr),
    .gpio_rd_data_i   (gpio_rd_data),
    .dma_rd_rd_data_i (dma_rd_rd_data),
    .dma_wr_rd_data_i (dma_wr_rd_data)
  );

  // Pins match by name
  gpio_regs u_gpio_regs (
    .*,
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb),
    .rd_addr_i (rd_addr),
    .rd_data_o (gpio_rd_data)
  );

  dma_desc_channel #(
    .BASE_ADDR (`REG_DMA_RD_BASE)
  ) u_dma_rd (
    .pcie_clk         (pcie_clk),
    .pcie_rst         (pcie_rst),
    .wr_en_i          (wr_en),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .rd_en_i          (rd_en),
    .rd_addr_i        (rd_addr),
    .rd_data_o        (dma_rd_rd_data),
    .desc_pcie_addr_o (dma_rd_desc_pcie_addr_o),
    .desc_ram_addr_o  (dma_rd_desc_ram_addr_o),
    .desc_len_o       (dma_rd_desc_len_o),
    .desc_tag_o       (dma_rd_desc_tag_o),
    .desc_valid_o     (dma_rd_desc_valid_o),
    .desc_ready_i     (dma_rd_desc_ready_i),
    .status_tag_i     (dma_rd_status_tag_i),
    .status_valid_i   (dma_rd_status_valid_i)
  );

  dma_desc_channel #(
    .BASE_ADDR (`REG_DMA_WR_BASE)
  ) u_dma_wr (
    .pcie_clk         (pcie_clk),
    .pcie_rst         (pcie_rst),
    .wr_en_i          (wr_en),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .rd_en_i          (rd_en),
    .rd_addr_i        (rd_addr),
    .rd_data_o        (dma_wr_rd_data),
    .desc_pcie_addr_o (dma_wr_desc_pcie_addr_o),
    .desc_ram_addr_o  (dma_wr_desc_ram_addr_o),
    .desc_len_o       (dma_wr_desc_len_o),
    .desc_tag_o       (dma_wr_desc_tag_o),
    .desc_valid_o     (dma_wr_desc_valid_o),
    .desc_ready_i     (dma_wr_desc_ready_i),
    .status_tag_i     (dma_wr_status_tag_i),
    .status_valid_i   (dma_wr_status_valid_i)
  );

endmodule

// File: verification/clk_gen.sv
module clk_gen (
  output logic pcie_clk_o,
  output logic pcie_rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    pcie_clk_o = 1'b0;
    forever #10 pcie_clk_o = ~pcie_clk_o;
  end

  // Reset held for the first 3 rising edges
  initial begin
    pcie_rst_o = 1'b1;
    repeat (3) @(posedge pcie_clk_o);
    pcie_rst_o <= 1'b0;
  end

endmodule

// File: verification/tb_pcie_config_top.sv
`include "pcie_config_params.svh"

module desc_responder (
  input  logic                   clk_i,
  input  logic                   valid_i,
  input  dma_desc_pkg::dma_tag_t tag_i,
  output logic                   ready_o,
  output dma_desc_pkg::dma_tag_t status_tag_o,
  output logic                   status_valid_o,
  output int                     done_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import dma_desc_pkg::*;

  integer   seed;
  int       delay;
  dma_tag_t tag;

  initial begin
    seed = 60;
    ready_o = 1'b0;
    status_tag_o = '0;
    status_valid_o = 1'b0;
    done_cnt_o = 0;
    forever begin
      @(negedge clk_i);
      if (valid_i) begin
        tag = tag_i;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_i);
        ready_o = 1'b1;
        @(negedge clk_i);
        ready_o = 1'b0;
        // Completion reported once the descriptor is gone
        status_tag_o = tag;
        status_valid_o = 1'b1;
        @(negedge clk_i);
        status_valid_o = 1'b0;
        done_cnt_o++;
      end
    end
  end

endmodule

module tb_pcie_config_top;
  timeunit 1ns;
  timeprecision 1ps;
  import cfg_regs_pkg::*;
  import dma_desc_pkg::*;

  localparam int TIMEOUT_CYC = 50;

  typedef struct packed {
    reg_addr_t addr;
    reg_data_t wdata;
    reg_strb_t strb;
    logic      do_wr;
    reg_data_t exp;
  } step_t;

  logic       pcie_clk;
  logic       pcie_rst;
  reg_addr_t  awaddr_i;
  logic       awvalid_i;
  logic       awready_o;
  reg_data_t  wdata_i;
  reg_strb_t  wstrb_i;
  logic       wvalid_i;
  logic       wready_o;
  logic [1:0] bresp_o;
  logic       bvalid_o;
  logic       bready_i;
  reg_addr_t  araddr_i;
  logic       arvalid_i;
  logic       arready_o;
  reg_data_t  rdata_o;
  logic [1:0] rresp_o;
  logic       rvalid_o;
  logic       rready_i;
  pcie_addr_t dma_rd_desc_pcie_addr_o;
  ram_addr_t  dma_rd_desc_ram_addr_o;
  dma_len_t   dma_rd_desc_len_o;
  dma_tag_t   dma_rd_desc_tag_o;
  logic       dma_rd_desc_valid_o;
  logic       dma_rd_desc_ready_i;
  dma_tag_t   dma_rd_status_tag_i;
  logic       dma_rd_status_valid_i;
  pcie_addr_t dma_wr_desc_pcie_addr_o;
  ram_addr_t  dma_wr_desc_ram_addr_o;
  dma_len_t   dma_wr_desc_len_o;
  dma_tag_t   dma_wr_desc_tag_o;
  logic       dma_wr_desc_valid_o;
  logic       dma_wr_desc_ready_i;
  dma_tag_t   dma_wr_status_tag_i;
  logic       dma_wr_status_valid_i;
  logic       qsfp0_modsell_o;
  logic       qsfp0_resetl_o;
  logic       qsfp0_lpmode_o;
  logic       qsfp0_modprsl_i;
  logic       qsfp0_intl_i;
  logic       qsfp1_modsell_o;
  logic       qsfp1_resetl_o;
  logic       qsfp1_lpmode_o;
  logic       qsfp1_modprsl_i;
  logic       qsfp1_intl_i;
  logic       i2c_scl_i;
  logic       i2c_scl_o;
  logic       i2c_scl_t_o;
  logic       i2c_sda_i;
  logic       i2c_sda_o;
  logic       i2c_sda_t_o;

  int        rd_done_cnt;
  int        wr_done_cnt;
  step_t     step_q[$];
  int        pass_cnt;
  int        err_cnt;
  reg_data_t rd;
  reg_data_t gpio_out_word;
  logic      seen;
  int        n;

  clk_gen u_clk_gen (
    .pcie_clk_o (pcie_clk),
    .pcie_rst_o (pcie_rst)
  );

  pcie_config_top u_pcie_config_top (.*);

  desc_responder u_rd_resp (
    .clk_i          (pcie_clk),
    .valid_i        (dma_rd_desc_valid_o),
    .tag_i          (dma_rd_desc_tag_o),
    .ready_o        (dma_rd_desc_ready_i),
    .status_tag_o   (dma_rd_status_tag_i),
    .status_valid_o (dma_rd_status_valid_i),
    .done_cnt_o     (rd_done_cnt)
  );

  desc_responder u_wr_resp (
    .clk_i          (pcie_clk),
    .valid_i        (dma_wr_desc_valid_o),
    .tag_i          (dma_wr_desc_tag_o),
    .ready_o        (dma_wr_desc_ready_i),
    .status_tag_o   (dma_wr_status_tag_i),
    .status_valid_o (dma_wr_status_valid_i),
    .done_cnt_o     (wr_done_cnt)
  );

  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d cycles", what, TIMEOUT_CYC);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic check_word(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end else begin
      $display("ok %s: %h", name, got);
      pass_cnt++;
    end
  endtask

  task automatic check_pin(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end else begin
      $display("ok %s: %h", name, got);
      pass_cnt++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got,
                            input logic [1:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end else begin
      $display("ok %s: %h", name, got);
      pass_cnt++;
    end
  endtask

  task automatic check_desc(input string name,
                            input pcie_addr_t got_addr, input ram_addr_t got_ram,
                            input dma_len_t got_len, input dma_tag_t got_tag,
                            input pcie_addr_t exp_addr, input ram_addr_t exp_ram,
                            input dma_len_t exp_len, input dma_tag_t exp_tag);
    if (got_addr !== exp_addr || got_ram !== exp_ram || got_len !== exp_len ||
        got_tag !== exp_tag) begin
      $write("mismatch %s: got addr %h ram %h len %h tag %h", name,
             got_addr, got_ram, got_len, got_tag);
      $display(" expected addr %h ram %h len %h tag %h",
               exp_addr, exp_ram, exp_len, exp_tag);
      err_cnt++;
    end else begin
      $display("ok %s: addr %h tag %h", name, got_addr, got_tag);
      pass_cnt++;
    end
  endtask

  task automatic start_write(input reg_addr_t addr, input reg_data_t data,
                             input reg_strb_t strb);
    @(negedge pcie_clk);
    awaddr_i = addr;
    wdata_i = data;
    wstrb_i = strb;
    awvalid_i = 1'b1;
    wvalid_i = 1'b1;
  endtask

  task automatic finish_write();
    int cnt;
    cnt = 0;
    @(negedge pcie_clk);
    while (!awready_o) begin
      cnt++;
      if (cnt > TIMEOUT_CYC) report_timeout("write acceptance");
      @(negedge pcie_clk);
    end
    // Both ready strobes and the response come with the acceptance edge
    check_pin("wready_o", wready_o, 1'b1);
    check_resp("bresp_o", bresp_o, 2'b00);
    awvalid_i = 1'b0;
    wvalid_i = 1'b0;
  endtask

  task automatic axil_write(input reg_addr_t addr, input reg_data_t data,
                            input reg_strb_t strb);
    start_write(addr, data, strb);
    finish_write();
  endtask

  task automatic axil_read(input reg_addr_t addr, output reg_data_t data);
    int cnt;
    cnt = 0;
    @(negedge pcie_clk);
    araddr_i = addr;
    arvalid_i = 1'b1;
    @(negedge pcie_clk);
    while (!rvalid_o) begin
      cnt++;
      if (cnt > TIMEOUT_CYC) report_timeout("read data");
      @(negedge pcie_clk);
    end
    check_pin("arready_o", arready_o, 1'b1);
    check_resp("rresp_o", rresp_o, 2'b00);
    data = rdata_o;
    arvalid_i = 1'b0;
  endtask

  task automatic add_read(input reg_addr_t addr, input reg_data_t exp);
    step_q.push_back('{addr, '0, '0, 1'b0, exp});
  endtask

  task automatic add_write(input reg_addr_t addr, input reg_data_t data,
                           input reg_strb_t strb, input reg_data_t exp);
    step_q.push_back('{addr, data, strb, 1'b1, exp});
  endtask

  function automatic logic chan_valid(input logic ch);
    return ch ? dma_wr_desc_valid_o : dma_rd_desc_valid_o;
  endfunction

  function automatic int chan_done(input logic ch);
    return ch ? wr_done_cnt : rd_done_cnt;
  endfunction

  // Output bits 0,2,4,6,9,11 plus the synchronized pin levels
  function automatic reg_data_t gpio_in_expect(input reg_data_t out_word,
                                               input logic modprsl0, input logic intl0,
                                               input logic modprsl1, input logic intl1,
                                               input logic scl, input logic sda);
    reg_data_t w;
    w = out_word & 32'h0000_0A55;
    w[1] = intl0;
    w[5] = intl1;
    w[8] = modprsl0;
    w[10] = modprsl1;
    w[16] = scl;
    w[17] = sda;
    return w;
  endfunction

  task automatic run_desc(input logic ch, input pcie_addr_t addr, input ram_addr_t ram,
                          input dma_len_t len, input dma_tag_t tag);
    reg_addr_t base;
    int        done_before;
    int        cnt;
    base = ch ? `REG_DMA_WR_BASE : `REG_DMA_RD_BASE;
    done_before = chan_done(ch);
    axil_write(base + `DESC_OFS_ADDR_LO, addr[31:0], 4'hF);
    axil_write(base + `DESC_OFS_ADDR_HI, addr[63:32], 4'hF);
    axil_write(base + `DESC_OFS_RAM, ram, 4'hF);
    axil_write(base + `DESC_OFS_LEN, reg_data_t'(len), 4'hF);
    axil_write(base + `DESC_OFS_TAG, tag, 4'hF);
    cnt = 0;
    while (!chan_valid(ch)) begin
      cnt++;
      if (cnt > TIMEOUT_CYC) report_timeout("descriptor valid");
      @(negedge pcie_clk);
    end
    if (ch) begin
      check_desc("dma_wr_desc", dma_wr_desc_pcie_addr_o, dma_wr_desc_ram_addr_o,
                 dma_wr_desc_len_o, dma_wr_desc_tag_o, addr, ram, len, tag);
    end else begin
      check_desc("dma_rd_desc", dma_rd_desc_pcie_addr_o, dma_rd_desc_ram_addr_o,
                 dma_rd_desc_len_o, dma_rd_desc_tag_o, addr, ram, len, tag);
    end
    cnt = 0;
    while (chan_valid(ch)) begin
      cnt++;
      if (cnt > TIMEOUT_CYC) report_timeout("descriptor release");
      @(negedge pcie_clk);
    end
    // Responder count moves on falling edges
    cnt = 0;
    @(posedge pcie_clk);
    while (chan_done(ch) == done_before) begin
      cnt++;
      if (cnt > TIMEOUT_CYC) report_timeout("descriptor completion");
      @(posedge pcie_clk);
    end
    @(negedge pcie_clk);
  endtask

  initial begin
    pass_cnt = 0;
    err_cnt = 0;
    awaddr_i = '0;
    awvalid_i = 1'b0;
    wdata_i = '0;
    wstrb_i = '0;
    wvalid_i = 1'b0;
    bready_i = 1'b1;
    araddr_i = '0;
    arvalid_i = 1'b0;
    rready_i = 1'b1;
    qsfp0_modprsl_i = 1'b0;
    qsfp0_intl_i = 1'b1;
    qsfp1_modprsl_i = 1'b0;
    qsfp1_intl_i = 1'b1;
    i2c_scl_i = 1'b1;
    i2c_sda_i = 1'b1;

    add_read(`REG_FW_ID, `FW_ID);
    add_read(`REG_FW_VER, `FW_VER);
    add_read(`REG_BOARD_ID, `BOARD_ID);
    add_read(`REG_BOARD_VER, `BOARD_VER);
    add_read(`REG_IF_COUNT, `IF_COUNT);
    add_read(`REG_IF_STRIDE, `IF_STRIDE);
    add_read(`REG_IF_CTRL_OFFSET, `IF_CTRL_OFFSET);
    add_read(`REG_FPGA_ID, `FPGA_ID);
    add_read(16'h0010, 32'h0);
    add_read(16'h044C, 32'h0);
    add_read(16'hFFF0, 32'h0);
    // Power-up GPIO word, then byte-wise updates
    add_read(`REG_GPIO_OUT, 32'h0003_0A11);
    add_write(`REG_GPIO_OUT, 32'hFFFF_FFFF, 4'b0001, 32'h0003_0A55);
    add_write(`REG_GPIO_OUT, 32'h0000_0000, 4'b0010, 32'h0003_0055);
    add_write(`REG_GPIO_OUT, 32'hFFFF_FFFF, 4'b1000, 32'h0003_0055);
    add_write(`REG_GPIO_OUT, 32'h0001_0800, 4'b0110, 32'h0001_0855);

    n = 0;
    @(negedge pcie_clk);
    while (pcie_rst) begin
      n++;
      if (n > TIMEOUT_CYC) report_timeout("reset release");
      @(negedge pcie_clk);
    end

    foreach (step_q[i]) begin
      if (step_q[i].do_wr) begin
        axil_write(step_q[i].addr, step_q[i].wdata, step_q[i].strb);
      end
      axil_read(step_q[i].addr, rd);
      check_word($sformatf("step %0d addr %h", i, step_q[i].addr), rd, step_q[i].exp);
    end

    // Pins lag the register by two stages
    gpio_out_word = step_q[step_q.size()-1].exp;
    repeat (3) @(negedge pcie_clk);
    check_pin("qsfp0_resetl_o", qsfp0_resetl_o, gpio_out_word[0]);
    check_pin("qsfp0_lpmode_o", qsfp0_lpmode_o, gpio_out_word[2]);
    check_pin("qsfp1_resetl_o", qsfp1_resetl_o, gpio_out_word[4]);
    check_pin("qsfp1_lpmode_o", qsfp1_lpmode_o, gpio_out_word[6]);
    check_pin("qsfp0_modsell_o", qsfp0_modsell_o, gpio_out_word[9]);
    check_pin("qsfp1_modsell_o", qsfp1_modsell_o, gpio_out_word[11]);
    check_pin("i2c_scl_o", i2c_scl_o, gpio_out_word[16]);
    check_pin("i2c_sda_o", i2c_sda_o, gpio_out_word[17]);
    check_pin("i2c_scl_t_o", i2c_scl_t_o, gpio_out_word[16]);
    check_pin("i2c_sda_t_o", i2c_sda_t_o, gpio_out_word[17]);

    qsfp0_modprsl_i = 1'b1;
    qsfp0_intl_i = 1'b0;
    qsfp1_modprsl_i = 1'b1;
    qsfp1_intl_i = 1'b0;
    i2c_scl_i = 1'b0;
    i2c_sda_i = 1'b1;
    repeat (4) @(negedge pcie_clk);
    axil_read(`REG_GPIO_IN, rd);
    check_word("gpio_in", rd, gpio_in_expect(gpio_out_word, 1'b1, 1'b0, 1'b1, 1'b0,
                                             1'b0, 1'b1));

    run_desc(1'b0, 64'h0000_0012_3456_7000, 32'h0001_0000, 16'h0800, 32'h0000_0001);
    run_desc(1'b0, 64'h0000_00AB_0000_1000, 32'h0002_0000, 16'h0040, 32'h0000_0004);
    axil_read(`REG_DMA_RD_BASE + `DESC_OFS_STATUS, rd);
    check_word("dma_rd status", rd, 32'h0000_0001 | 32'h0000_0004);
    axil_read(`REG_DMA_RD_BASE + `DESC_OFS_STATUS, rd);
    check_word("dma_rd status after clear", rd, 32'h0);

    run_desc(1'b1, 64'h0000_0001_8000_0000, 32'h0003_0100, 16'h1000, 32'h0000_0002);
    run_desc(1'b1, 64'h0000_0000_0000_2000, 32'h0000_0200, 16'h0010, 32'h0000_0010);
    axil_read(`REG_DMA_WR_BASE + `DESC_OFS_STATUS, rd);
    check_word("dma_wr status", rd, 32'h0000_0002 | 32'h0000_0010);
    axil_read(`REG_DMA_WR_BASE + `DESC_OFS_STATUS, rd);
    check_word("dma_wr status after clear", rd, 32'h0);

    // Write response stalled, second write must wait
    bready_i = 1'b0;
    axil_write(`REG_GPIO_OUT, 32'h0000_0011, 4'hF);
    start_write(`REG_GPIO_OUT, 32'h0003_0A55, 4'hF);
    seen = 1'b0;
    repeat (4) begin
      @(negedge pcie_clk);
      seen = seen | awready_o;
    end
    check_pin("awready_o under back-pressure", seen, 1'b0);
    check_pin("bvalid_o under back-pressure", bvalid_o, 1'b1);
    bready_i = 1'b1;
    finish_write();
    axil_read(`REG_GPIO_OUT, rd);
    check_word("gpio_out after back-pressure", rd, 32'h0003_0A55);

    $display("checks: %0d passed, %0d failed", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: pcie_config_top.f
+incdir+rtl
rtl/cfg_regs_pkg.sv
rtl/dma_desc_pkg.sv
rtl/axil_reg_port.sv
rtl/gpio_regs.sv
rtl/dma_desc_channel.sv
rtl/pcie_config_top.sv
verification/clk_gen.sv
verification/tb_pcie_config_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_pcie_config_top \
  -f pcie_config_top.f \
  -o sim_tb &&
./obj_dir/sim_tb | tee sim.log &&
! grep -q "Simulation finished: FAIL" sim.log &&
grep -q "Simulation finished: PASS" sim.log &&
echo "run_sim.sh: run passed" ||
{ echo "run_sim.sh: run failed"; exit 1; }
